//--- design/buffer_config.svh
//////////////////////////////////////////////////
// sample buffer sizing macros
// channel count, bank depth, sample width and the widths derived from them
//////////////////////////////////////////////////

`ifndef BUFFER_CONFIG_SVH
`define BUFFER_CONFIG_SVH

// parallel adc channels, one memory bank each (power of two)
`define BUF_CHANNELS 4
// samples per bank (power of two)
`define BUF_DEPTH 16
// bits per sample
`define BUF_DATA_W 16

// derived widths
`define BUF_ADDR_W $clog2(`BUF_DEPTH)
`define BUF_SEL_W $clog2(`BUF_CHANNELS)
// banking mode selects 2**mode active channels, mode 0 .. BUF_SEL_W
`define BUF_MODE_W $clog2(`BUF_SEL_W + 1)

`endif

//--- design/buffer_pkg.sv
//////////////////////////////////////////////////
// shared types for the sample buffer
// capture and readout state encodings, per-bank depth word
//////////////////////////////////////////////////

`include "buffer_config.svh"

package buffer_pkg;

  // capture side FSM
  // idle -> trigger wait on arm, -> save on start, -> hold on stop or full
  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_TRIGGER_WAIT,
    CAP_SAVE,
    CAP_HOLD
  } capture_state_e;

  // readout side FSM
  // ready means a finished capture is waiting to be streamed out
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_READY,
    RD_ACTIVE
  } readout_state_e;

  // depth of one bank after a capture
  // count wraps to zero when the bank is full, so full sits above it
  typedef struct packed {
    logic                   full;
    logic [`BUF_ADDR_W-1:0] count;
  } bank_depth_t;

endpackage

//--- design/buffer_if.sv
//////////////////////////////////////////////////
// capture_if  control to writer handshake
// bank_mem_if  per-bank write port and muxed read port
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "buffer_config.svh"

interface capture_if;
  // one cycle pulse when capture begins, reloads the valid mask
  logic                 start_pulse;
  // set/reset flop, gates all write enables
  logic                 capture_active;
  // 1, 2, 4 .. BUF_CHANNELS
  logic [`BUF_SEL_W:0]  active_channels;
  // last sample taken by a bank at a full-mask position
  logic                 full_hit;

  modport ctrl (
    output start_pulse, capture_active, active_channels,
    input  full_hit
  );

  modport writer (
    input  start_pulse, capture_active, active_channels,
    output full_hit
  );
endinterface

interface bank_mem_if;
  // write side, one port per bank
  logic [`BUF_CHANNELS-1:0]                  write_en;
  logic [`BUF_CHANNELS-1:0][`BUF_ADDR_W-1:0] write_addr;
  logic [`BUF_CHANNELS-1:0][`BUF_DATA_W-1:0] write_data;

  // read side, common address plus a bank select
  logic [`BUF_ADDR_W-1:0] read_addr;
  logic [`BUF_SEL_W-1:0]  bank_sel;
  logic                   read_en;
  logic [`BUF_DATA_W-1:0] read_data;

  modport writer (output write_en, write_addr, write_data);

  modport reader (output read_addr, bank_sel, read_en, input read_data);

  modport memory (
    input  write_en, write_addr, write_data, read_addr, bank_sel, read_en,
    output read_data
  );
endinterface

//--- design/capture_control.sv
//////////////////////////////////////////////////
// capture FSM with start/stop gating
// banking mode register and capture done pulse
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "buffer_config.svh"

module capture_control (
  input  logic                   adc_clk,
  input  logic                   adc_reset,
  // command stream, cmd = {arm, start, stop}
  input  logic                   cmd_valid,
  input  logic [2:0]             cmd,
  output logic                   cmd_ready,
  // banking mode stream
  input  logic                   mode_valid,
  input  logic [`BUF_MODE_W-1:0] banking_mode,
  output logic                   mode_ready,
  // hardware trigger levels
  input  logic                   capture_hw_start,
  input  logic                   capture_hw_stop,
  input  logic                   readout_done,
  input  logic                   capture_full,
  output logic                   capture_done,
  capture_if.ctrl                cap
);

  buffer_pkg::capture_state_e state;
  logic                cmd_ok;
  logic                arm, sw_start, sw_stop;
  logic                start_pulse, stop_pulse;
  logic                capture_active;
  logic [`BUF_SEL_W:0] active_channels;
  logic                capture_full_d;

  // commands are refused while holding samples for readout
  assign cmd_ready  = state != buffer_pkg::CAP_HOLD;
  assign mode_ready = state == buffer_pkg::CAP_IDLE;

  assign cmd_ok   = cmd_valid & cmd_ready;
  assign arm      = cmd_ok & cmd[2];
  assign sw_start = cmd_ok & cmd[1];
  assign sw_stop  = cmd_ok & cmd[0];

  // any start counts once armed, only a software start works from idle
  // arm wins over a start in the same command
  assign start_pulse = ((capture_hw_start | sw_start) & (state == buffer_pkg::CAP_TRIGGER_WAIT))
                     | (sw_start & ~arm & (state == buffer_pkg::CAP_IDLE));
  assign stop_pulse  = (capture_hw_stop | sw_stop) & (state == buffer_pkg::CAP_SAVE);

  assign cap.start_pulse     = start_pulse;
  assign cap.capture_active  = capture_active;
  assign cap.active_channels = active_channels;

  //////////////////////////////////////////////////
  // banking mode, all channels after reset
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      active_channels <= (`BUF_SEL_W + 1)'(`BUF_CHANNELS);
    end else if (mode_valid & mode_ready) begin
      active_channels <= (`BUF_SEL_W + 1)'(1) << banking_mode;
    end
  end

  // capture_active set/reset flop
  // cleared on stop or as soon as the last full-mask bank fills
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      capture_active <= 1'b0;
    end else if (start_pulse) begin
      capture_active <= 1'b1;
    end else if (stop_pulse | cap.full_hit) begin
      capture_active <= 1'b0;
    end
  end

  // done pulse on stop or on rising edge of capture_full
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      capture_full_d <= 1'b0;
      capture_done   <= 1'b0;
    end else begin
      capture_full_d <= capture_full;
      capture_done   <= stop_pulse | (capture_full & ~capture_full_d);
    end
  end

  //////////////////////////////////////////////////
  // state transitions
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state <= buffer_pkg::CAP_IDLE;
    end else begin
      case (state)
        buffer_pkg::CAP_IDLE: begin
          if (arm) begin
            state <= buffer_pkg::CAP_TRIGGER_WAIT;
          end else if (start_pulse) begin
            state <= buffer_pkg::CAP_SAVE;
          end
        end
        buffer_pkg::CAP_TRIGGER_WAIT: begin
          if (start_pulse) begin
            state <= buffer_pkg::CAP_SAVE;
          end
        end
        buffer_pkg::CAP_SAVE: begin
          if (stop_pulse | capture_full) begin
            state <= buffer_pkg::CAP_HOLD;
          end
        end
        default: begin
          // hold until the stream has been fully read out
          if (readout_done) begin
            state <= buffer_pkg::CAP_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- design/bank_writer.sv
//////////////////////////////////////////////////
// bank write side: valid mask chaining, input mux,
// write addresses, full latches, depth report
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "buffer_config.svh"

module bank_writer (
  input  logic                                      adc_clk,
  input  logic                                      adc_reset,
  input  logic [`BUF_CHANNELS-1:0][`BUF_DATA_W-1:0] adc_data,
  input  logic [`BUF_CHANNELS-1:0]                  adc_valid,
  input  logic                                      readout_done,
  capture_if.writer                                 cap,
  bank_mem_if.writer                                mem,
  output logic                                      capture_full,
  output buffer_pkg::bank_depth_t [`BUF_CHANNELS-1:0] write_depth
);

  logic [`BUF_CHANNELS-1:0][`BUF_DATA_W-1:0] data_d;
  logic [`BUF_CHANNELS-1:0]                  valid_d;
  logic [`BUF_CHANNELS-1:0][`BUF_SEL_W-1:0]  src_sel;
  logic [`BUF_SEL_W-1:0]                     chan_mask;
  logic [`BUF_CHANNELS-1:0]                  full_mask, valid_mask;
  logic [`BUF_CHANNELS-1:0]                  write_enable, bank_full;
  logic [`BUF_CHANNELS-1:0]                  full_latch, latch_nxt;
  logic [`BUF_CHANNELS-1:0][`BUF_ADDR_W-1:0] write_addr, addr_nxt;

  // active count is a power of two, so modulo is a mask of the low bits
  assign chan_mask = cap.active_channels[`BUF_SEL_W-1:0] - 1'b1;

  // input register stage
  always_ff @(posedge adc_clk) begin
    data_d  <= adc_data;
    valid_d <= adc_valid;
  end

  //////////////////////////////////////////////////
  // per-bank enables and next address / full state
  //////////////////////////////////////////////////
  always_comb begin
    for (int b = 0; b < `BUF_CHANNELS; b++) begin
      // bank b is fed by channel b mod active
      src_sel[b]      = `BUF_SEL_W'(b) & chan_mask;
      // top banks mark the end of the chain
      // e.g. 4 banks, 1 active -> 1000, 2 active -> 1100, 4 active -> 1111
      full_mask[b]    = (b + cap.active_channels) >= `BUF_CHANNELS;
      write_enable[b] = cap.capture_active & valid_mask[b] & valid_d[src_sel[b]];
      bank_full[b]    = write_enable[b] & (&write_addr[b]);
      addr_nxt[b]     = write_enable[b] ? write_addr[b] + 1'b1 : write_addr[b];
      latch_nxt[b]    = full_latch[b] | bank_full[b];
    end
    // finished readout frees the whole memory
    if (readout_done) begin
      addr_nxt  = '0;
      latch_nxt = '0;
    end
  end

  assign cap.full_hit = |(bank_full & full_mask);
  assign capture_full = |(full_latch & full_mask);

  // valid mask, reloaded on start with the lowest active banks
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_mask <= '0;
    end else if (cap.start_pulse) begin
      for (int b = 0; b < `BUF_CHANNELS; b++) begin
        valid_mask[b] <= b < cap.active_channels;
      end
    end else begin
      for (int b = 0; b < `BUF_CHANNELS; b++) begin
        if (bank_full[b]) begin
          // retire this bank and hand its channel to the next bank in the chain
          valid_mask[b] <= 1'b0;
          if (b + cap.active_channels < `BUF_CHANNELS) begin
            valid_mask[b + cap.active_channels] <= 1'b1;
          end
        end
      end
    end
  end

  // address counters and full latches
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      write_addr <= '0;
      full_latch <= '0;
    end else begin
      write_addr <= addr_nxt;
      full_latch <= latch_nxt;
    end
  end

  // depth words include the write of this cycle
  always_ff @(posedge adc_clk) begin
    for (int b = 0; b < `BUF_CHANNELS; b++) begin
      write_depth[b].full  <= latch_nxt[b];
      write_depth[b].count <= addr_nxt[b];
    end
  end

  //////////////////////////////////////////////////
  // memory write port, one cycle behind the enables
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      mem.write_en <= '0;
    end else begin
      mem.write_en <= write_enable;
    end
  end

  always_ff @(posedge adc_clk) begin
    mem.write_addr <= write_addr;
    for (int b = 0; b < `BUF_CHANNELS; b++) begin
      mem.write_data[b] <= data_d[src_sel[b]];
    end
  end

endmodule

//--- design/sample_memory.sv
//////////////////////////////////////////////////
// per-bank sample RAMs
// independent writes, one registered muxed read
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "buffer_config.svh"

module sample_memory (
  input  logic        adc_clk,
  bank_mem_if.memory  mem
);

  // word at the shared read address, from every bank
  logic [`BUF_CHANNELS-1:0][`BUF_DATA_W-1:0] bank_word;

  for (genvar b = 0; b < `BUF_CHANNELS; b++) begin : g_bank
    logic [`BUF_DATA_W-1:0] ram [`BUF_DEPTH];

    always_ff @(posedge adc_clk) begin
      if (mem.write_en[b]) begin
        ram[mem.write_addr[b]] <= mem.write_data[b];
      end
    end

    assign bank_word[b] = ram[mem.read_addr];
  end

  // read register holds its word while the readout is stalled
  always_ff @(posedge adc_clk) begin
    if (mem.read_en) begin
      mem.read_data <= bank_word[mem.bank_sel];
    end
  end

endmodule

//--- design/readout_engine.sv
//////////////////////////////////////////////////
// readout FSM, address and bank walk,
// stall-able read pipeline to the output stream
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "buffer_config.svh"

module readout_engine (
  input  logic                   adc_clk,
  input  logic                   adc_reset,
  input  logic                   capture_done,
  input  logic                   readout_start_valid,
  output logic                   readout_start_ready,
  output logic [`BUF_DATA_W-1:0] readout_data,
  output logic                   readout_valid,
  output logic                   readout_last,
  input  logic                   readout_ready,
  output logic                   readout_done,
  bank_mem_if.reader             mem
);

  buffer_pkg::readout_state_e state;
  logic                   start_ok;
  logic                   advance;
  logic                   issuing;
  logic                   read_en;
  logic                   at_last;
  logic [`BUF_ADDR_W-1:0] read_addr;
  logic [`BUF_SEL_W-1:0]  bank_sel;
  // valid and last travelling alongside the memory read register
  logic                   pipe_valid, pipe_last;

  assign readout_start_ready = state == buffer_pkg::RD_READY;
  assign start_ok = readout_start_valid & readout_start_ready;

  // the whole pipeline moves only when the output slot is free or taken
  assign advance = readout_ready | ~readout_valid;
  assign read_en = issuing & advance;
  assign at_last = (&read_addr) & (&bank_sel);

  assign readout_done = readout_valid & readout_ready & readout_last;

  assign mem.read_addr = read_addr;
  assign mem.bank_sel  = bank_sel;
  assign mem.read_en   = read_en;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state <= buffer_pkg::RD_IDLE;
    end else begin
      case (state)
        buffer_pkg::RD_IDLE:  if (capture_done) state <= buffer_pkg::RD_READY;
        buffer_pkg::RD_READY: if (start_ok) state <= buffer_pkg::RD_ACTIVE;
        default:              if (readout_done) state <= buffer_pkg::RD_IDLE;
      endcase
    end
  end

  // issue flag, high from start until the final address is read
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      issuing <= 1'b0;
    end else if (start_ok) begin
      issuing <= 1'b1;
    end else if (read_en & at_last) begin
      issuing <= 1'b0;
    end
  end

  // bank-major walk, address wraps into the next bank
  always_ff @(posedge adc_clk) begin
    if (adc_reset | start_ok) begin
      {bank_sel, read_addr} <= '0;
    end else if (read_en) begin
      {bank_sel, read_addr} <= {bank_sel, read_addr} + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // output pipeline
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      pipe_valid    <= 1'b0;
      pipe_last     <= 1'b0;
      readout_valid <= 1'b0;
      readout_last  <= 1'b0;
    end else if (advance) begin
      pipe_valid    <= read_en;
      pipe_last     <= read_en & at_last;
      readout_valid <= pipe_valid;
      readout_last  <= pipe_last;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (advance) begin
      readout_data <= mem.read_data;
    end
  end

endmodule

//--- design/sample_buffer_top.sv
//////////////////////////////////////////////////
// sample buffer top level
// plain stream ports around capture, write, memory and readout
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "buffer_config.svh"

module sample_buffer_top (
  input  logic                                     adc_clk,
  input  logic                                     adc_reset,
  // channel samples, channel 0 in the low bits
  input  logic [`BUF_CHANNELS*`BUF_DATA_W-1:0]     adc_data,
  input  logic [`BUF_CHANNELS-1:0]                 adc_valid,
  input  logic                                     capture_hw_start,
  input  logic                                     capture_hw_stop,
  output logic                                     capture_full,
  // {arm, start, stop}
  input  logic                                     cmd_valid,
  input  logic [2:0]                               cmd,
  output logic                                     cmd_ready,
  input  logic                                     mode_valid,
  input  logic [`BUF_MODE_W-1:0]                   banking_mode,
  output logic                                     mode_ready,
  input  logic                                     readout_start_valid,
  output logic                                     readout_start_ready,
  output logic [`BUF_DATA_W-1:0]                   readout_data,
  output logic                                     readout_valid,
  input  logic                                     readout_ready,
  output logic                                     readout_last,
  // one {full, count} word per bank, bank 0 in the low bits
  output logic [`BUF_CHANNELS*(`BUF_ADDR_W+1)-1:0] write_depth,
  output logic                                     write_depth_valid
);

  logic capture_done;
  logic readout_done;
  buffer_pkg::bank_depth_t [`BUF_CHANNELS-1:0] depth_words;

  capture_if  cap_if ();
  bank_mem_if mem_if ();

  // depth report is valid in the capture done cycle
  assign write_depth       = depth_words;
  assign write_depth_valid = capture_done;

  capture_control u_capture_control (
    .adc_clk, .adc_reset,
    .cmd_valid, .cmd, .cmd_ready,
    .mode_valid, .banking_mode, .mode_ready,
    .capture_hw_start, .capture_hw_stop,
    .readout_done, .capture_full, .capture_done,
    .cap (cap_if.ctrl)
  );

  bank_writer u_bank_writer (
    .adc_clk, .adc_reset,
    .adc_data, .adc_valid,
    .readout_done,
    .cap          (cap_if.writer),
    .mem          (mem_if.writer),
    .capture_full,
    .write_depth  (depth_words)
  );

  sample_memory u_sample_memory (
    .adc_clk,
    .mem (mem_if.memory)
  );

  readout_engine u_readout_engine (
    .adc_clk, .adc_reset,
    .capture_done,
    .readout_start_valid, .readout_start_ready,
    .readout_data, .readout_valid, .readout_last, .readout_ready,
    .readout_done,
    .mem (mem_if.reader)
  );

endmodule

//--- tb/sample_buffer_tests.svh
//////////////////////////////////////////////////
// stimulus tasks, bank content model and
// the directed tests of the sample buffer
//////////////////////////////////////////////////

`ifndef SAMPLE_BUFFER_TESTS_SVH
`define SAMPLE_BUFFER_TESTS_SVH

// command bits {arm, start, stop}
localparam logic [2:0] CMD_ARM   = 3'b100;
localparam logic [2:0] CMD_START = 3'b010;
localparam logic [2:0] CMD_STOP  = 3'b001;

// expected bank contents kept across captures like the memory itself
logic [DATA_W-1:0] model_mem   [CHANNELS][DEPTH];
bit                model_known [CHANNELS][DEPTH];
// samples written per bank and taken per channel in this capture
int                bank_fill   [CHANNELS];
int                chan_count  [CHANNELS];
int                model_active = CHANNELS;
bit                model_capturing;

task automatic next_cycle();
  @(posedge adc_clk);
  #1;
endtask

task automatic send_cmd(input logic [2:0] code);
  int waited;
  waited = 0;
  while (!cmd_ready && waited < 100) begin
    next_cycle();
    waited++;
  end
  if (!cmd_ready) begin
    report_failure("cmd_ready stayed low");
    return;
  end
  cmd_valid = 1'b1;
  cmd       = code;
  next_cycle();
  cmd_valid = 1'b0;
endtask

task automatic set_mode(input int mode);
  if (!mode_ready) begin
    report_failure("mode_ready low when a mode was to be set");
    return;
  end
  mode_valid   = 1'b1;
  banking_mode = `BUF_MODE_W'(mode);
  next_cycle();
  mode_valid   = 1'b0;
  // 2**mode channels are active
  model_active = 1 << mode;
endtask

task automatic start_model();
  for (int b = 0; b < CHANNELS; b++) begin
    bank_fill[b]  = 0;
    chan_count[b] = 0;
  end
  model_capturing = 1'b1;
endtask

// drives one cycle of random samples on every channel
task automatic present_samples(input logic [CHANNELS-1:0] valid);
  logic [DATA_W-1:0] sample;
  int                bank;
  int                addr;
  bit                hit;
  hit = 1'b0;
  for (int c = 0; c < CHANNELS; c++) begin
    sample = DATA_W'($urandom);
    adc_data[c*DATA_W +: DATA_W] = sample;
    // channel c fills bank c first and then banks c + active and c + 2*active
    if (valid[c] && model_capturing && c < model_active) begin
      bank = c + model_active * (chan_count[c] / DEPTH);
      addr = chan_count[c] % DEPTH;
      model_mem[bank][addr]   = sample;
      model_known[bank][addr] = 1'b1;
      bank_fill[bank]++;
      chan_count[c]++;
      // the last bank of a chain filled so capture ends for all channels
      if (bank_fill[bank] == DEPTH && bank + model_active >= CHANNELS) begin
        hit = 1'b1;
      end
    end
  end
  adc_valid = valid;
  if (hit) begin
    model_capturing = 1'b0;
  end
  next_cycle();
endtask

task automatic stop_capture();
  send_cmd(CMD_STOP);
  model_capturing = 1'b0;
endtask

// waits up to max_wait cycles for the depth pulse and then compares every bank
task automatic check_depth_report(input int max_wait);
  int              waited;
  logic [ADDR_W:0] expected;
  logic [ADDR_W:0] actual;
  waited = 0;
  while (!write_depth_valid && waited < max_wait) begin
    next_cycle();
    waited++;
  end
  if (!write_depth_valid) begin
    report_failure("write_depth_valid did not pulse in time");
    return;
  end
  for (int b = 0; b < CHANNELS; b++) begin
    // full flag above a count that wraps to zero
    expected = {bank_fill[b] == DEPTH, ADDR_W'(bank_fill[b])};
    actual   = write_depth[b*(ADDR_W+1) +: ADDR_W+1];
    check_equal($sformatf("depth of bank %0d", b), 32'(expected), 32'(actual));
  end
  next_cycle();
  check_equal("write_depth_valid after pulse", 0, 32'(write_depth_valid));
endtask

//////////////////////////////////////////////////
// readout in bank-major order against the model
//////////////////////////////////////////////////
task automatic run_readout(input bit random_ready);
  int waited;
  int word;
  int bank;
  int addr;
  waited = 0;
  while (!readout_start_ready && waited < 100) begin
    next_cycle();
    waited++;
  end
  if (!readout_start_ready) begin
    report_failure("readout_start_ready never went high");
    return;
  end
  readout_start_valid = 1'b1;
  next_cycle();
  readout_start_valid = 1'b0;
  word   = 0;
  waited = 0;
  while (word < WORDS && waited < 20 * WORDS) begin
    readout_ready = random_ready ? (($urandom & 1) != 0) : 1'b1;
    if (readout_valid && readout_ready) begin
      bank = word / DEPTH;
      addr = word % DEPTH;
      // never written words hold unknown data
      if (model_known[bank][addr]) begin
        check_equal($sformatf("data of word %0d", word), 32'(model_mem[bank][addr]),
                    32'(readout_data));
      end
      check_equal($sformatf("last of word %0d", word), 32'(word == WORDS - 1),
                  32'(readout_last));
      word++;
    end
    next_cycle();
    waited++;
  end
  readout_ready = 1'b0;
  if (word < WORDS) begin
    report_failure($sformatf("readout stopped after %0d of %0d words", word, WORDS));
    return;
  end
  check_equal("readout_valid after last word", 0, 32'(readout_valid));
  check_equal("cmd_ready after readout", 1, 32'(cmd_ready));
  check_equal("mode_ready after readout", 1, 32'(mode_ready));
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////
task automatic ready_flags_test();
  begin_test("ready_flags");
  check_equal("readout_start_ready after reset", 0, 32'(readout_start_ready));
  check_equal("cmd_ready after reset", 1, 32'(cmd_ready));
  check_equal("mode_ready after reset", 1, 32'(mode_ready));
  check_equal("capture_full after reset", 0, 32'(capture_full));
  check_equal("readout_valid after reset", 0, 32'(readout_valid));
  send_cmd(CMD_START);
  start_model();
  // save state
  check_equal("mode_ready in save", 0, 32'(mode_ready));
  check_equal("cmd_ready in save", 1, 32'(cmd_ready));
  repeat (3) present_samples('1);
  present_samples('0);
  check_equal("readout_start_ready before done", 0, 32'(readout_start_ready));
  stop_capture();
  check_depth_report(0);
  // hold state until the readout finishes
  check_equal("cmd_ready in hold", 0, 32'(cmd_ready));
  check_equal("mode_ready in hold", 0, 32'(mode_ready));
  check_equal("readout_start_ready after capture", 1, 32'(readout_start_ready));
  run_readout(1'b0);
  finish_test();
endtask

task automatic software_capture_test();
  begin_test("software_capture");
  set_mode(2);
  send_cmd(CMD_START);
  start_model();
  repeat (5) present_samples('1);
  present_samples('0);
  stop_capture();
  // five samples per bank and no bank full
  check_depth_report(0);
  run_readout(1'b0);
  finish_test();
endtask

task automatic single_channel_test();
  int n;
  begin_test("single_channel");
  set_mode(0);
  send_cmd(CMD_START);
  start_model();
  n = 0;
  // other channels toggle randomly and must be ignored
  while (model_capturing && n < 4 * WORDS) begin
    present_samples(CHANNELS'($urandom) | CHANNELS'(1));
    n++;
  end
  present_samples('0);
  check_depth_report(10);
  check_equal("capture_full after fill", 1, 32'(capture_full));
  run_readout(1'b0);
  check_equal("capture_full after readout", 0, 32'(capture_full));
  finish_test();
endtask

task automatic hardware_trigger_test();
  begin_test("hardware_trigger");
  set_mode(2);
  model_capturing  = 1'b0;
  capture_hw_start = 1'b1;
  // not armed so nothing is captured
  repeat (4) present_samples('1);
  capture_hw_start = 1'b0;
  // a capture started by mistake would end here and report its depth
  capture_hw_stop = 1'b1;
  present_samples('0);
  capture_hw_stop = 1'b0;
  check_equal("write_depth_valid while unarmed", 0, 32'(write_depth_valid));
  check_equal("mode_ready while unarmed", 1, 32'(mode_ready));
  send_cmd(CMD_ARM);
  check_equal("mode_ready in trigger wait", 0, 32'(mode_ready));
  // stop only counts in the save state
  capture_hw_stop = 1'b1;
  next_cycle();
  capture_hw_stop = 1'b0;
  check_equal("write_depth_valid in trigger wait", 0, 32'(write_depth_valid));
  capture_hw_start = 1'b1;
  next_cycle();
  capture_hw_start = 1'b0;
  start_model();
  repeat (10) present_samples(CHANNELS'($urandom));
  present_samples('0);
  capture_hw_stop = 1'b1;
  next_cycle();
  capture_hw_stop = 1'b0;
  model_capturing = 1'b0;
  check_depth_report(0);
  run_readout(1'b0);
  finish_test();
endtask

task automatic random_ready_test();
  int n;
  begin_test("random_ready");
  // two channels chained over four banks
  set_mode(1);
  send_cmd(CMD_START);
  start_model();
  n = 0;
  while (model_capturing && n < 4 * WORDS) begin
    present_samples(CHANNELS'($urandom));
    n++;
  end
  present_samples('0);
  check_depth_report(10);
  run_readout(1'b1);
  finish_test();
endtask

`endif

//--- tb/tb_sample_buffer.sv
//////////////////////////////////////////////////
// testbench for the sample buffer
// clock, reset, DUT, timeout, check task, summary
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "buffer_config.svh"

module tb_sample_buffer;

  localparam int CHANNELS = `BUF_CHANNELS;
  localparam int DEPTH    = `BUF_DEPTH;
  localparam int DATA_W   = `BUF_DATA_W;
  localparam int ADDR_W   = `BUF_ADDR_W;
  localparam int WORDS    = CHANNELS * DEPTH;
  // five tests of at most ~400 cycles each (random ready readout is the longest),
  // doubled for margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic                           adc_clk;
  logic                           adc_reset;
  logic [CHANNELS*DATA_W-1:0]     adc_data;
  logic [CHANNELS-1:0]            adc_valid;
  logic                           capture_hw_start;
  logic                           capture_hw_stop;
  logic                           capture_full;
  logic                           cmd_valid;
  logic [2:0]                     cmd;
  logic                           cmd_ready;
  logic                           mode_valid;
  logic [`BUF_MODE_W-1:0]         banking_mode;
  logic                           mode_ready;
  logic                           readout_start_valid;
  logic                           readout_start_ready;
  logic [DATA_W-1:0]              readout_data;
  logic                           readout_valid;
  logic                           readout_ready;
  logic                           readout_last;
  logic [CHANNELS*(ADDR_W+1)-1:0] write_depth;
  logic                           write_depth_valid;

  int    error_count;
  int    check_count;
  int    test_count;
  int    test_start_errors;
  int    cycle_count;
  string current_test;

  sample_buffer_top u_sample_buffer_top (.*);

  // 4 ns clock
  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  // watchdog, ends a run that stalls
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge adc_clk);
      cycle_count++;
    end
    $display("timeout: run stopped after %0d cycles in test %s", cycle_count, current_test);
    $display(">>> FAIL");
    $finish;
  end

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch in test %s: %s expected 0x%0h, actual 0x%0h",
               current_test, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("Error in test %s: %s", current_test, msg);
  endtask

  task automatic begin_test(input string name);
    current_test      = name;
    test_start_errors = error_count;
  endtask

  task automatic finish_test();
    test_count++;
    if (error_count == test_start_errors) begin
      $display("test %s: ok", current_test);
    end else begin
      $display("test %s: %0d errors", current_test, error_count - test_start_errors);
    end
  endtask

  `include "sample_buffer_tests.svh"

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h8547_4fbe));
    error_count         = 0;
    check_count         = 0;
    test_count          = 0;
    current_test        = "reset";
    adc_reset           = 1'b1;
    adc_data            = '0;
    adc_valid           = '0;
    capture_hw_start    = 1'b0;
    capture_hw_stop     = 1'b0;
    cmd_valid           = 1'b0;
    cmd                 = '0;
    mode_valid          = 1'b0;
    banking_mode        = '0;
    readout_start_valid = 1'b0;
    readout_ready       = 1'b0;
    repeat (5) @(posedge adc_clk);
    #1;
    adc_reset = 1'b0;

    // ready flags first, readout_start_ready is checked before any capture
    ready_flags_test();
    software_capture_test();
    single_channel_test();
    hardware_trigger_test();
    random_ready_test();

    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+design
+incdir+tb
design/buffer_pkg.sv
design/buffer_if.sv
design/capture_control.sv
design/bank_writer.sv
design/sample_memory.sv
design/readout_engine.sv
design/sample_buffer_top.sv
tb/tb_sample_buffer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sample buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sample_buffer \
  -f flist.f --Mdir obj_dir -o tb_sample_buffer
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sample_buffer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0
